//--- files.f
+incdir+source
source/vdp_pkg.sv
source/video_timing.sv
source/tile_fetch_fsm.sv
source/vram_port.sv
source/pixel_shifter.sv
source/palette.sv
source/vdp_top.sv
verif/vdp_sva.sv
verif/vdp_tb.sv

//--- Makefile
TOP := vdp_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f files.f --top-module $(TOP) -o vdp_sim

run: build
	./obj_dir/vdp_sim +verilator+error+limit+100 | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/vdp_tb.sv
`timescale 1ns/10ps
`include "vdp_defines.svh"

module vdp_tb import vdp_pkg::*; ();
  localparam int SIG_DE = 0;
  localparam int SIG_HS = 1;
  localparam int SIG_VS = 2;
  localparam int SIG_INT = 3;
  localparam int SIG_RSP = 4;
  localparam int FRAME_LIMIT = 500000;
  localparam int FRAME_CYCLES = `VDP_H_TOTAL * `VDP_V_TOTAL;
  localparam vram_addr_t NAME_BASE = 14'h1800;
  localparam vram_addr_t PAT_BASE = 14'h0000;
  localparam vram_addr_t COL_BASE = 14'h2000;

  logic                   clk;
  logic                   reset;
  vdp_cfg_t               cfg;
  logic                   req_valid;
  cpu_req_t               req;
  logic                   rsp_ready;
  logic                   req_ready;
  logic                   rsp_valid;
  logic [`VDP_DATA_W-1:0] rsp_data;
  logic [7:0]             vga_r;
  logic [7:0]             vga_g;
  logic [7:0]             vga_b;
  logic                   vga_hs;
  logic                   vga_vs;
  logic                   vga_de;
  logic                   n_int;

  // Model of video RAM and palette contents
  logic [7:0] mem_img [1 << `VDP_ADDR_W];
  rgb_t       pal [16];
  logic [31:0] lcg_state;
  int errors;
  int checks;
  int tests;
  int col;
  int line;
  int pix_checked;
  logic prev_de;
  logic compare_on;

  vdp_top DUT (.*);

  always #50 clk = ~clk;

  function automatic logic [7:0] lcg_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  function automatic rgb_t expected_rgb(int x, int y);
    color_idx_t idx;
    logic [7:0] name;
    logic [7:0] pat;
    logic [7:0] colr;
    int px;
    int py;
    int ni;
    if (x < 64 || x >= 576 || y < 48 || y >= 432 || !cfg.video_on) begin
      idx = cfg.backdrop;
    end else begin
      px = (x - 64) / 2;
      py = (y - 48) / 2;
      name = mem_img[cfg.name_base + vram_addr_t'((py / 8) * 32 + px / 8)];
      ni = name;
      pat = mem_img[cfg.pattern_base + vram_addr_t'(ni * 8 + py % 8)];
      colr = mem_img[cfg.color_base + vram_addr_t'(ni / 8)];
      idx = pat[7 - px % 8] ? colr[7:4] : colr[3:0];
    end
    // Color 0 is transparent
    if (idx == 4'd0)
      idx = cfg.backdrop;
    if (idx == 4'd0)
      return '0;
    return pal[idx];
  endfunction

  function automatic void note_error();
    errors++;
  endfunction

  task automatic check_rgb(string name, rgb_t got, rgb_t exp);
    checks++;
    if (got !== exp) begin
      if (errors < 50)
        $display("Mismatch %s: got %h expected %h", name, got, exp);
      note_error();
    end
  endtask

  task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      note_error();
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    checks++;
    if (got != exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      note_error();
    end
  endtask

  function automatic logic sig_value(int which);
    case (which)
      SIG_DE:  return vga_de;
      SIG_HS:  return vga_hs;
      SIG_VS:  return vga_vs;
      SIG_INT: return n_int;
      SIG_RSP: return rsp_valid;
      default: return req_ready;
    endcase
  endfunction

  task automatic timeout_fail(string what);
    $display("Timeout while waiting for %s", what);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  task automatic wait_level(int which, logic level, int limit, string what);
    int n;
    n = 0;
    while (sig_value(which) !== level) begin
      @(negedge clk);
      n++;
      if (n > limit)
        timeout_fail(what);
    end
  endtask

  // Cycles the signal stays at the given level
  task automatic count_level(int which, logic level, int limit, string what, output int n);
    n = 0;
    while (sig_value(which) === level) begin
      @(negedge clk);
      n++;
      if (n > limit)
        timeout_fail(what);
    end
  endtask

  task automatic cpu_send(cpu_op_e op, vram_addr_t addr, logic [7:0] data);
    int n;
    n = 0;
    req_valid = 1'b1;
    req = '{op: op, addr: addr, data: data};
    while (!req_ready) begin
      @(negedge clk);
      n++;
      if (n > 100)
        timeout_fail("req_ready");
    end
    @(negedge clk);
    req_valid = 1'b0;
    if (op == OP_WRITE_VRAM)
      mem_img[addr] = data;
  endtask

  task automatic cpu_read(vram_addr_t addr, int hold, output logic [7:0] data);
    cpu_send(OP_READ, addr, 8'h00);
    wait_level(SIG_RSP, 1'b1, 100, "rsp_valid");
    // Response not taken yet, no new request accepted
    repeat (hold) begin
      check_byte("req_ready", {7'd0, req_ready}, 8'h00);
      @(negedge clk);
    end
    rsp_ready = 1'b1;
    data = rsp_data;
    @(negedge clk);
    rsp_ready = 1'b0;
  endtask

  task automatic write_palette(color_idx_t idx, logic [5:0] d);
    cpu_send(OP_WRITE_PALETTE, vram_addr_t'(idx), {2'b00, d});
    pal[idx] = '{r: {d[1:0], 6'b0}, g: {d[3:2], 6'b0}, b: {d[5:4], 6'b0}};
  endtask

  task automatic compare_frame();
    wait_level(SIG_VS, 1'b0, FRAME_LIMIT, "vga_vs low");
    wait_level(SIG_VS, 1'b1, FRAME_LIMIT, "vga_vs high");
    pix_checked = 0;
    compare_on = 1'b1;
    wait_level(SIG_VS, 1'b0, FRAME_LIMIT, "vga_vs low");
    compare_on = 1'b0;
    check_count("pixels checked", pix_checked, `VDP_H_ACTIVE * `VDP_V_ACTIVE);
  endtask

  task automatic end_test(string name, int errs_before);
    tests++;
    $display("Test %s done with %0d errors", name, errors - errs_before);
  endtask

  // Pixel compare, raster position follows vga_de
  always @(negedge clk) begin
    if (!reset) begin
      if (vga_de) begin
        if (compare_on) begin
          check_rgb("rgb", {vga_r, vga_g, vga_b}, expected_rgb(col, line));
          pix_checked++;
        end
        col++;
      end else if (prev_de) begin
        line++;
        col = 0;
      end
      if (!vga_vs)
        line = 0;
      prev_de = vga_de;
    end
  end

  initial begin
    int e0;
    int n;
    int lines;
    int addrs [32];
    logic [7:0] d;
    logic was_de;
    clk = 1'b0;
    reset = 1'b1;
    cfg = '{name_base: NAME_BASE, pattern_base: PAT_BASE, color_base: COL_BASE,
            backdrop: 4'd4, video_on: 1'b0, int_enable: 1'b0};
    req_valid = 1'b0;
    req = '0;
    rsp_ready = 1'b0;
    lcg_state = 32'd39112;
    errors = 0;
    checks = 0;
    tests = 0;
    col = 0;
    line = 0;
    prev_de = 1'b0;
    compare_on = 1'b0;
    pal = '{24'h000000, 24'h010101, 24'h3eb849, 24'h74d07d,
            24'h5955e0, 24'h8076f1, 24'h993e31, 24'h65dbef,
            24'hdb6559, 24'hff897d, 24'hccc35e, 24'hded087,
            24'h3aa241, 24'hb766b5, 24'h777777, 24'hffffff};
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    e0 = errors;
    wait_level(SIG_VS, 1'b0, FRAME_LIMIT, "vga_vs low");
    count_level(SIG_VS, 1'b0, FRAME_LIMIT, "vga_vs high", n);
    check_count("vsync cycles", n, `VDP_V_SYNC * `VDP_H_TOTAL);
    lines = 0;
    n = 0;
    was_de = vga_de;
    while (vga_vs) begin
      @(negedge clk);
      if (vga_de && !was_de)
        lines++;
      was_de = vga_de;
      n++;
      if (n > FRAME_LIMIT)
        timeout_fail("end of frame");
    end
    check_count("active lines", lines, `VDP_V_ACTIVE);
    wait_level(SIG_VS, 1'b1, FRAME_LIMIT, "vga_vs high");
    wait_level(SIG_DE, 1'b1, FRAME_LIMIT, "vga_de high");
    count_level(SIG_DE, 1'b1, 1000, "vga_de low", n);
    check_count("de cycles", n, `VDP_H_ACTIVE);
    count_level(SIG_DE, 1'b0, 1000, "vga_de high", lines);
    check_count("line cycles", n + lines, `VDP_H_TOTAL);
    wait_level(SIG_HS, 1'b0, 1000, "vga_hs low");
    count_level(SIG_HS, 1'b0, 1000, "vga_hs high", n);
    check_count("hsync cycles", n, `VDP_H_SYNC);
    end_test("raster", e0);

    e0 = errors;
    for (int i = 0; i < 32; i++) begin
      addrs[i] = {lcg_byte(), lcg_byte()} & 16'h3fff;
      cpu_send(OP_WRITE_VRAM, vram_addr_t'(addrs[i]), lcg_byte());
    end
    for (int i = 0; i < 32; i++) begin
      cpu_read(vram_addr_t'(addrs[i]), lcg_byte() % 4, d);
      check_byte("rsp_data", d, mem_img[addrs[i]]);
    end
    end_test("vram access", e0);

    e0 = errors;
    for (int i = 0; i < `VDP_COLS * `VDP_ROWS; i++)
      cpu_send(OP_WRITE_VRAM, NAME_BASE + vram_addr_t'(i), lcg_byte());
    for (int i = 0; i < 2048; i++)
      cpu_send(OP_WRITE_VRAM, PAT_BASE + vram_addr_t'(i), lcg_byte());
    for (int i = 0; i < 32; i++)
      cpu_send(OP_WRITE_VRAM, COL_BASE + vram_addr_t'(i), lcg_byte());
    cfg.video_on = 1'b1;
    compare_frame();
    end_test("tile rendering", e0);

    e0 = errors;
    write_palette(4'd1, 6'(lcg_byte()));
    write_palette(4'd4, 6'(lcg_byte()));
    write_palette(4'd9, 6'(lcg_byte()));
    write_palette(4'd15, 6'(lcg_byte()));
    // Entry 0 stays hidden behind the backdrop
    write_palette(4'd0, 6'h3f);
    compare_frame();
    end_test("palette", e0);

    e0 = errors;
    cfg.int_enable = 1'b1;
    wait_level(SIG_VS, 1'b1, FRAME_LIMIT, "vga_vs high");
    wait_level(SIG_VS, 1'b0, FRAME_LIMIT, "vga_vs low");
    // n_int falls 656 columns after the start of vertical sync
    count_level(SIG_INT, 1'b1, 1000, "n_int low", n);
    check_count("n_int start column", n, `VDP_H_ACTIVE + `VDP_H_FP);
    count_level(SIG_INT, 1'b0, 1000, "n_int high", n);
    check_count("n_int low cycles", n, `VDP_INT_CYCLES);
    count_level(SIG_INT, 1'b1, FRAME_LIMIT, "next n_int", lines);
    check_count("n_int period", n + lines, FRAME_CYCLES);
    cfg.int_enable = 1'b0;
    wait_level(SIG_INT, 1'b1, 1000, "end of n_int pulse");
    n = 0;
    repeat (FRAME_CYCLES + 1000) begin
      @(negedge clk);
      if (!n_int)
        n++;
    end
    check_count("n_int low while disabled", n, 0);
    cfg.video_on = 1'b0;
    compare_frame();
    // Backdrop 0 is transparent too and gives black
    cfg.backdrop = 4'd0;
    compare_frame();
    end_test("interrupt and blanking", e0);

    n = DUT.u_sva.fail_count;
    errors += n;
    $display("Tests: %0d, checks: %0d, errors: %0d, assertion failures: %0d",
             tests, checks, errors, n);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- verif/vdp_sva.sv
`timescale 1ns/10ps

module vdp_sva import vdp_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       req_valid,
  input cpu_req_t   req,
  input logic       req_ready,
  input logic       rsp_valid,
  input logic       rsp_ready,
  input logic       vga_de,
  input logic [7:0] vga_r,
  input logic [7:0] vga_g,
  input logic [7:0] vga_b,
  input logic       n_int
);
  int fail_count = 0;
  int low_cnt;

  always_ff @(posedge clk) begin
    if (reset || n_int)
      low_cnt <= 0;
    else
      low_cnt <= low_cnt + 1;
  end

  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    (req_valid && !req_ready) |=> (req_valid && $stable(req)))
    else begin $error("request changed before acceptance"); fail_count++; end

  a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
    (rsp_valid && !rsp_ready) |=> rsp_valid)
    else begin $error("response dropped before rsp_ready"); fail_count++; end

  a_rgb_blank: assert property (@(posedge clk) disable iff (reset)
    !vga_de |-> ({vga_r, vga_g, vga_b} == 24'd0))
    else begin $error("RGB not zero outside vga_de"); fail_count++; end

  a_int_len: assert property (@(posedge clk) disable iff (reset)
    low_cnt <= 64)
    else begin $error("n_int low for too long"); fail_count++; end

endmodule

bind vdp_top vdp_sva u_sva (.*);

//--- source/vdp_top.sv
`timescale 1ns/10ps
`include "vdp_defines.svh"

module vdp_top import vdp_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  vdp_cfg_t               cfg,
  input  logic                   req_valid,
  input  cpu_req_t               req,
  input  logic                   rsp_ready,
  output logic                   req_ready,
  output logic                   rsp_valid,
  output logic [`VDP_DATA_W-1:0] rsp_data,
  output logic [7:0]             vga_r,
  output logic [7:0]             vga_g,
  output logic [7:0]             vga_b,
  output logic                   vga_hs,
  output logic                   vga_vs,
  output logic                   vga_de,
  output logic                   n_int
);
  // Tile position derived from the raster counters
  logic [4:0]             tile_col;
  logic [4:0]             tile_row;
  logic [2:0]             tile_line;
  logic [2:0]             tile_pix;
  logic                   border;
  logic                   fetch_start;
  vram_addr_t             disp_addr;
  logic [`VDP_DATA_W-1:0] disp_data;
  logic [`VDP_DATA_W-1:0] pattern_byte;
  logic [`VDP_DATA_W-1:0] color_byte;
  logic                   load;
  pal_wr_t                pal_wr;
  color_idx_t             color_idx;
  rgb_t                   rgb;

  video_timing u_timing (
    .clk(clk), .reset(reset), .int_enable(cfg.int_enable),
    .hc(), .vc(),
    .tile_col(tile_col), .tile_row(tile_row),
    .tile_line(tile_line), .tile_pix(tile_pix),
    .border(border), .fetch_start(fetch_start),
    .hs(vga_hs), .vs(vga_vs), .de(vga_de), .n_int(n_int)
  );

  tile_fetch_fsm u_fetch (
    .clk(clk), .reset(reset), .fetch_start(fetch_start),
    .tile_col(tile_col), .tile_row(tile_row), .tile_line(tile_line),
    .video_on(cfg.video_on),
    .name_base(cfg.name_base), .pattern_base(cfg.pattern_base),
    .color_base(cfg.color_base),
    .disp_addr(disp_addr), .pattern_byte(pattern_byte),
    .color_byte(color_byte), .load(load), .disp_data(disp_data)
  );

  vram_port u_vram (
    .clk(clk), .reset(reset),
    .req_valid(req_valid), .req(req), .rsp_ready(rsp_ready),
    .req_ready(req_ready), .rsp_valid(rsp_valid), .rsp_data(rsp_data),
    .disp_addr(disp_addr), .disp_data(disp_data), .pal_wr(pal_wr)
  );

  pixel_shifter u_shifter (
    .clk(clk), .reset(reset), .load(load),
    .pattern_byte(pattern_byte), .color_byte(color_byte),
    .tile_pix(tile_pix), .border(border),
    .video_on(cfg.video_on), .backdrop(cfg.backdrop),
    .color_idx(color_idx)
  );

  palette u_palette (
    .clk(clk), .reset(reset), .pal_wr(pal_wr),
    .color_idx(color_idx), .backdrop(cfg.backdrop),
    .de(vga_de), .rgb(rgb)
  );

  assign vga_r = rgb.r;
  assign vga_g = rgb.g;
  assign vga_b = rgb.b;

endmodule

//--- source/palette.sv
`timescale 1ns/10ps

module palette import vdp_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  pal_wr_t    pal_wr,
  input  color_idx_t color_idx,
  input  color_idx_t backdrop,
  input  logic       de,
  output rgb_t       rgb
);
  // Standard MSX colors, entry 0 is transparent
  localparam rgb_t MSX_COLORS [16] = '{
    24'h000000, 24'h010101, 24'h3eb849, 24'h74d07d,
    24'h5955e0, 24'h8076f1, 24'h993e31, 24'h65dbef,
    24'hdb6559, 24'hff897d, 24'hccc35e, 24'hded087,
    24'h3aa241, 24'hb766b5, 24'h777777, 24'hffffff
  };

  rgb_t       entries [16];
  rgb_t       rgb_q;
  color_idx_t eff_idx;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 16; i++)
        entries[i] <= MSX_COLORS[i];
    end else if (pal_wr.en) begin
      // RGB222 into the top two bits of each channel
      entries[pal_wr.index].r <= {pal_wr.data[1:0], 6'b0};
      entries[pal_wr.index].g <= {pal_wr.data[3:2], 6'b0};
      entries[pal_wr.index].b <= {pal_wr.data[5:4], 6'b0};
    end
  end

  // Transparent pixels show the backdrop
  assign eff_idx = (color_idx == 4'd0) ? backdrop : color_idx;

  always_ff @(posedge clk) begin
    if (eff_idx == 4'd0)
      rgb_q <= '0;
    else
      rgb_q <= entries[eff_idx];
  end

  // Blank outside the active area
  assign rgb = de ? rgb_q : '0;

endmodule

//--- source/pixel_shifter.sv
`timescale 1ns/10ps
`include "vdp_defines.svh"

module pixel_shifter import vdp_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   load,
  input  logic [`VDP_DATA_W-1:0] pattern_byte,
  input  logic [`VDP_DATA_W-1:0] color_byte,
  input  logic [2:0]             tile_pix,
  input  logic                   border,
  input  logic                   video_on,
  input  color_idx_t             backdrop,
  output color_idx_t             color_idx
);
  logic [`VDP_DATA_W-1:0] pat_q;
  logic [`VDP_DATA_W-1:0] col_q;
  logic [`VDP_DATA_W-1:0] pat_cur;
  logic [`VDP_DATA_W-1:0] col_cur;
  logic                   pix_on;
  color_idx_t             tile_idx;

  always_ff @(posedge clk) begin
    if (load) begin
      pat_q <= pattern_byte;
      col_q <= color_byte;
    end
  end

  // Load arrives on the first pixel of the tile, so bypass the holding regs
  assign pat_cur = load ? pattern_byte : pat_q;
  assign col_cur = load ? color_byte : col_q;

  // Leftmost pixel is bit 7
  assign pix_on   = pat_cur[3'd7 - tile_pix];
  assign tile_idx = pix_on ? col_cur[7:4] : col_cur[3:0];

  always_ff @(posedge clk) begin
    if (reset)
      color_idx <= '0;
    else if (border || !video_on)
      color_idx <= backdrop;
    else
      color_idx <= tile_idx;
  end

endmodule

//--- source/vram_port.sv
`timescale 1ns/10ps
`include "vdp_defines.svh"

module vram_port import vdp_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   req_valid,
  input  cpu_req_t               req,
  input  logic                   rsp_ready,
  output logic                   req_ready,
  output logic                   rsp_valid,
  output logic [`VDP_DATA_W-1:0] rsp_data,
  input  vram_addr_t             disp_addr,
  output logic [`VDP_DATA_W-1:0] disp_data,
  output pal_wr_t                pal_wr
);
  localparam int DEPTH = 1 << `VDP_ADDR_W;

  logic [`VDP_DATA_W-1:0] mem [DEPTH];
  logic                   accept;

  // No new request while a read response waits to be taken
  assign req_ready = !rsp_valid;
  assign accept    = req_valid && req_ready;

  // CPU side, read and write
  always_ff @(posedge clk) begin
    if (accept && req.op == OP_WRITE_VRAM)
      mem[req.addr] <= req.data;
    if (accept && req.op == OP_READ)
      rsp_data <= mem[req.addr];
  end

  // Display side, read only
  always_ff @(posedge clk) begin
    disp_data <= mem[disp_addr];
  end

  always_ff @(posedge clk) begin
    if (reset)
      rsp_valid <= 1'b0;
    else if (accept && req.op == OP_READ)
      rsp_valid <= 1'b1;
    else if (rsp_ready)
      rsp_valid <= 1'b0;
  end

  // Palette entry number comes from the low address bits
  always_ff @(posedge clk) begin
    pal_wr.index <= req.addr[3:0];
    pal_wr.data  <= req.data[5:0];
    if (reset)
      pal_wr.en <= 1'b0;
    else
      pal_wr.en <= accept && (req.op == OP_WRITE_PALETTE);
  end

endmodule

//--- source/tile_fetch_fsm.sv
`timescale 1ns/10ps
`include "vdp_defines.svh"

module tile_fetch_fsm import vdp_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   fetch_start,
  input  logic [4:0]             tile_col,
  input  logic [4:0]             tile_row,
  input  logic [2:0]             tile_line,
  input  logic                   video_on,
  input  vram_addr_t             name_base,
  input  vram_addr_t             pattern_base,
  input  vram_addr_t             color_base,
  output vram_addr_t             disp_addr,
  output logic [`VDP_DATA_W-1:0] pattern_byte,
  output logic [`VDP_DATA_W-1:0] color_byte,
  output logic                   load,
  input  logic [`VDP_DATA_W-1:0] disp_data
);
  fetch_state_e           state;
  logic [4:0]             next_col;
  logic [`VDP_DATA_W-1:0] name_q;
  logic [`VDP_DATA_W-1:0] pat_q;
  logic                   ready;
  vram_addr_t             name_addr;
  vram_addr_t             pattern_addr;
  vram_addr_t             color_addr;

  // Name entry is row * 32 + column
  assign name_addr = name_base + vram_addr_t'({tile_row, next_col});
  // disp_data holds the name byte while in FETCH_PATTERN
  assign pattern_addr = pattern_base + vram_addr_t'({disp_data, tile_line});
  // One color byte per group of 8 tile numbers
  assign color_addr = color_base + vram_addr_t'(name_q[7:3]);

  always_comb begin
    case (state)
      FETCH_PATTERN: disp_addr = pattern_addr;
      FETCH_COLOR:   disp_addr = color_addr;
      default:       disp_addr = name_addr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset || !video_on) begin
      state <= FETCH_IDLE;
      ready <= 1'b0;
    end else begin
      case (state)
        FETCH_IDLE: begin
          if (fetch_start) begin
            state <= FETCH_NAME;
            ready <= 1'b0;
          end
        end
        FETCH_NAME:    state <= FETCH_PATTERN;
        FETCH_PATTERN: state <= FETCH_COLOR;
        FETCH_COLOR:   state <= FETCH_LOAD;
        FETCH_LOAD: begin
          state <= FETCH_IDLE;
          ready <= 1'b1;
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  // Fetched bytes wait here until the previous tile has been shown
  always_ff @(posedge clk) begin
    if (fetch_start)
      next_col <= tile_col + 5'd1;
    if (state == FETCH_PATTERN)
      name_q <= disp_data;
    if (state == FETCH_COLOR)
      pat_q <= disp_data;
    if (state == FETCH_LOAD) begin
      pattern_byte <= pat_q;
      color_byte   <= disp_data;
    end
  end

  // Next strobe is the first clock of the fetched tile
  assign load = fetch_start && ready && video_on;

endmodule

//--- source/video_timing.sv
`timescale 1ns/10ps
`include "vdp_defines.svh"

module video_timing (
  input  logic       clk,
  input  logic       reset,
  input  logic       int_enable,
  output logic [9:0] hc,
  output logic [9:0] vc,
  output logic [4:0] tile_col,
  output logic [4:0] tile_row,
  output logic [2:0] tile_line,
  output logic [2:0] tile_pix,
  output logic       border,
  output logic       fetch_start,
  output logic       hs,
  output logic       vs,
  output logic       de,
  output logic       n_int
);
  localparam logic [9:0] H_TOTAL  = 10'(`VDP_H_TOTAL);
  localparam logic [9:0] V_TOTAL  = 10'(`VDP_V_TOTAL);
  localparam logic [9:0] H_SYNC_S = 10'(`VDP_H_ACTIVE + `VDP_H_FP);
  localparam logic [9:0] H_SYNC_E = 10'(`VDP_H_ACTIVE + `VDP_H_FP + `VDP_H_SYNC);
  localparam logic [9:0] V_SYNC_S = 10'(`VDP_V_ACTIVE + `VDP_V_FP);
  localparam logic [9:0] V_SYNC_E = 10'(`VDP_V_ACTIVE + `VDP_V_FP + `VDP_V_SYNC);
  localparam logic [9:0] H_PIC_S  = 10'(`VDP_H_BORDER);
  localparam logic [9:0] H_PIC_E  = 10'(`VDP_H_BORDER + `VDP_COLS * 16);
  localparam logic [9:0] V_PIC_S  = 10'(`VDP_V_BORDER);
  localparam logic [9:0] V_PIC_E  = 10'(`VDP_V_BORDER + `VDP_ROWS * 16);
  // A tile is 16 clocks wide, its fetch starts one tile ahead
  localparam logic [9:0] FETCH_S  = H_PIC_S - 10'd16;
  localparam int         INT_W    = $clog2(`VDP_INT_CYCLES);

  logic [9:0]       hx;
  logic [9:0]       vy;
  logic             h_pic;
  logic             v_pic;
  logic [2:0]       sync_d1;
  logic [2:0]       sync_d2;
  logic             int_on;
  logic [INT_W-1:0] int_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      hc <= '0;
      vc <= '0;
    end else if (hc == H_TOTAL - 10'd1) begin
      hc <= '0;
      vc <= (vc == V_TOTAL - 10'd1) ? 10'd0 : vc + 10'd1;
    end else begin
      hc <= hc + 10'd1;
    end
  end

  // Screen pixel position relative to the top left of the picture
  assign hx = hc - H_PIC_S;
  assign vy = vc - V_PIC_S;
  assign tile_col  = hx[8:4];
  assign tile_pix  = hx[3:1];
  assign tile_row  = vy[8:4];
  assign tile_line = vy[3:1];

  assign h_pic  = (hc >= H_PIC_S) && (hc < H_PIC_E);
  assign v_pic  = (vc >= V_PIC_S) && (vc < V_PIC_E);
  assign border = !(h_pic && v_pic);

  assign fetch_start = v_pic && (hc >= FETCH_S) && (hc < H_PIC_E) && (hc[3:0] == 4'd0);

  // Sync and enable follow the two pipeline stages of the pixel path
  always_ff @(posedge clk) begin
    if (reset) begin
      sync_d1 <= 3'b110;
      sync_d2 <= 3'b110;
    end else begin
      sync_d1 <= {!((hc >= H_SYNC_S) && (hc < H_SYNC_E)),
                  !((vc >= V_SYNC_S) && (vc < V_SYNC_E)),
                  (hc < 10'(`VDP_H_ACTIVE)) && (vc < 10'(`VDP_V_ACTIVE))};
      sync_d2 <= sync_d1;
    end
  end

  assign hs = sync_d2[2];
  assign vs = sync_d2[1];
  assign de = sync_d2[0];

  // Triggered one clock early so n_int falls with output column 656
  always_ff @(posedge clk) begin
    if (reset) begin
      int_on  <= 1'b0;
      int_cnt <= '0;
    end else if (int_on) begin
      int_cnt <= int_cnt + 1'b1;
      if (int_cnt == INT_W'(`VDP_INT_CYCLES - 1))
        int_on <= 1'b0;
    end else if (int_enable && hc == H_SYNC_S + 10'd1 && vc == V_SYNC_S) begin
      int_on  <= 1'b1;
      int_cnt <= '0;
    end
  end

  assign n_int = !int_on;

endmodule

//--- source/vdp_pkg.sv
`include "vdp_defines.svh"

package vdp_pkg;

  typedef logic [`VDP_ADDR_W-1:0] vram_addr_t;
  typedef logic [3:0] color_idx_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  typedef enum logic [1:0] {
    OP_READ,
    OP_WRITE_VRAM,
    OP_WRITE_PALETTE
  } cpu_op_e;

  typedef struct packed {
    cpu_op_e                 op;
    vram_addr_t              addr;
    logic [`VDP_DATA_W-1:0]  data;
  } cpu_req_t;

  // Table bases and display controls, static while a frame is shown
  typedef struct packed {
    vram_addr_t  name_base;
    vram_addr_t  pattern_base;
    vram_addr_t  color_base;
    color_idx_t  backdrop;
    logic        video_on;
    logic        int_enable;
  } vdp_cfg_t;

  // Palette write, data is RGB222 with R in the low bits
  typedef struct packed {
    logic        en;
    color_idx_t  index;
    logic [5:0]  data;
  } pal_wr_t;

  typedef enum logic [2:0] {
    FETCH_IDLE,
    FETCH_NAME,
    FETCH_PATTERN,
    FETCH_COLOR,
    FETCH_LOAD
  } fetch_state_e;

endpackage

//--- source/vdp_defines.svh
`ifndef VDP_DEFINES_SVH
`define VDP_DEFINES_SVH

// Horizontal raster timing in VGA pixels, 640x480 at 60 Hz
`define VDP_H_ACTIVE 640
`define VDP_H_FP 16
`define VDP_H_SYNC 96
`define VDP_H_BP 48
`define VDP_H_TOTAL (`VDP_H_ACTIVE + `VDP_H_FP + `VDP_H_SYNC + `VDP_H_BP)

// Vertical raster timing in lines
`define VDP_V_ACTIVE 480
`define VDP_V_FP 11
`define VDP_V_SYNC 2
`define VDP_V_BP 31
`define VDP_V_TOTAL (`VDP_V_ACTIVE + `VDP_V_FP + `VDP_V_SYNC + `VDP_V_BP)

// Border around the 256x192 picture, in VGA pixels
`define VDP_H_BORDER 64
`define VDP_V_BORDER 48

// Tile grid of graphics mode 1
`define VDP_COLS 32
`define VDP_ROWS 24

// Video RAM geometry
`define VDP_ADDR_W 14
`define VDP_DATA_W 8

// Vertical retrace interrupt length in clocks
`define VDP_INT_CYCLES 64

`endif
